// ==== hdl/ioCtrl_defines.svh ====
`ifndef IOCTRL_DEFINES_SVH
`define IOCTRL_DEFINES_SVH

// Data word carried by every channel and by the accumulator
`define IO_WORD_W 16

// Device channels, numbered from the first device code upward
`define IO_NUM_CHAN 9

// Device code served by channel 0, channel k serves code 7+k
`define IO_FIRST_DEV 7

// Device code field, instruction bits 5:0
`define IO_CODE_W 6

// Processor pseudo-device
`define IO_CPU_CODE 63

// Wide enough to index all channels
`define IO_CHAN_IDX_W 4

`endif

// ==== hdl/ioCtrlPkg.sv ====
`default_nettype none

package ioCtrlPkg;

    // Instruction bits 10:8, codes 3, 5 and 6 are ignored
    typedef enum logic [2:0] {
        NIO  = 3'd0,
        DIA  = 3'd1,
        DOA  = 3'd2,
        MSKO = 3'd4,
        SKP  = 3'd7
    } ioFunc_t;

    // Instruction bits 7:6
    // For SKP the same field picks busy, not busy, done, not done
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        START = 2'd1,
        CLEAR = 2'd2,
        PULSE = 2'd3
    } ioPulse_t;

    // Per-channel command from the decoder
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2,
        TEST  = 2'd3
    } chanCmd_t;

endpackage

`default_nettype wire

// ==== hdl/ioInstDecode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ioCtrl_defines.svh"

module ioInstDecode (
    input  wire                            SZMNC,
    input  wire                            rst_DRL,
    input  wire                            i_instValid,
    input  wire [`IO_WORD_W-1:0]           i_inst,
    input  wire [`IO_WORD_W-1:0]           i_acc,
    output logic [`IO_NUM_CHAN-1:0]        o_chanSel,
    output ioCtrlPkg::chanCmd_t            o_chanCmd,
    output ioCtrlPkg::ioPulse_t            o_pulse,
    output logic [`IO_WORD_W-1:0]          o_acc,
    output logic [`IO_CHAN_IDX_W-1:0]      o_chanIdx,
    output logic                           o_devRead,
    output logic                           o_skipTest,
    output logic                           o_cpuEnable,
    output logic                           o_cpuDisable,
    output logic                           o_cpuMask,
    output logic                           o_cpuAck
);
    localparam logic [`IO_CODE_W-1:0] firstDev = `IO_CODE_W'(`IO_FIRST_DEV);
    localparam logic [`IO_CODE_W-1:0] lastDev  = `IO_CODE_W'(`IO_FIRST_DEV + `IO_NUM_CHAN - 1);
    localparam logic [`IO_CODE_W-1:0] cpuCode  = `IO_CODE_W'(`IO_CPU_CODE);

    logic                      isIo;
    ioCtrlPkg::ioFunc_t        func;
    ioCtrlPkg::ioPulse_t       pulse;
    logic [`IO_CODE_W-1:0]     code;
    logic [`IO_CODE_W-1:0]     codeOff;
    logic                      isChan;
    logic                      cpuOk;
    logic                      funcOk;
    logic                      chanOk;
    ioCtrlPkg::chanCmd_t       cmdNext;
    logic [`IO_NUM_CHAN-1:0]   selNext;

    // I/O class is 0,1,1 in bits 15:13
    assign isIo    = i_instValid && !i_inst[15] && i_inst[14] && i_inst[13];
    assign func    = ioCtrlPkg::ioFunc_t'(i_inst[10:8]);
    assign pulse   = ioCtrlPkg::ioPulse_t'(i_inst[7:6]);
    assign code    = i_inst[`IO_CODE_W-1:0];
    assign codeOff = code - firstDev;
    assign isChan  = (code >= firstDev) && (code <= lastDev);
    assign cpuOk   = isIo && (code == cpuCode);

    always_comb begin
        funcOk  = 1'b1;
        cmdNext = ioCtrlPkg::IDLE;
        case (func)
            ioCtrlPkg::NIO: cmdNext = ioCtrlPkg::IDLE;
            ioCtrlPkg::DIA: cmdNext = ioCtrlPkg::READ;
            ioCtrlPkg::DOA: cmdNext = ioCtrlPkg::WRITE;
            ioCtrlPkg::SKP: cmdNext = ioCtrlPkg::TEST;
            // MSKO belongs to code 63 only
            default:        funcOk  = 1'b0;
        endcase
    end

    assign chanOk  = isIo && isChan && funcOk;
    assign selNext = chanOk ? (`IO_NUM_CHAN'(1) << codeOff[`IO_CHAN_IDX_W-1:0]) : '0;

    always_ff @(posedge SZMNC or posedge rst_DRL) begin
        if (rst_DRL) begin
            o_chanSel    <= '0;
            o_chanCmd    <= ioCtrlPkg::IDLE;
            o_devRead    <= 1'b0;
            o_skipTest   <= 1'b0;
            o_cpuEnable  <= 1'b0;
            o_cpuDisable <= 1'b0;
            o_cpuMask    <= 1'b0;
            o_cpuAck     <= 1'b0;
        end else begin
            o_chanSel    <= selNext;
            o_chanCmd    <= chanOk ? cmdNext : ioCtrlPkg::IDLE;
            o_devRead    <= chanOk && (func == ioCtrlPkg::DIA);
            o_skipTest   <= chanOk && (func == ioCtrlPkg::SKP);
            // Interrupt on/off through NIO pulse field
            o_cpuEnable  <= cpuOk && (func == ioCtrlPkg::NIO) && (pulse == ioCtrlPkg::START);
            o_cpuDisable <= cpuOk && (func == ioCtrlPkg::NIO) && (pulse == ioCtrlPkg::CLEAR);
            o_cpuMask    <= cpuOk && (func == ioCtrlPkg::MSKO);
            o_cpuAck     <= cpuOk && (func == ioCtrlPkg::DIA);
        end
    end

    always_ff @(posedge SZMNC) begin
        o_acc     <= i_acc;
        o_pulse   <= pulse;
        o_chanIdx <= codeOff[`IO_CHAN_IDX_W-1:0];
    end

endmodule

`default_nettype wire

// ==== hdl/devChannel.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ioCtrl_defines.svh"

module devChannel (
    input  wire                        SZMNC,
    input  wire                        rst_DRL,
    input  wire                        i_sel,
    input  wire ioCtrlPkg::chanCmd_t   i_cmd,
    input  wire ioCtrlPkg::ioPulse_t   i_pulse,
    input  wire [`IO_WORD_W-1:0]       i_acc,
    input  wire [`IO_WORD_W-1:0]       i_devInData,
    input  wire                        i_devDone,
    output logic                       o_busy,
    output logic                       o_done,
    output logic [`IO_WORD_W-1:0]      o_inBuf,
    output logic [`IO_WORD_W-1:0]      o_outBuf,
    output logic                       o_start,
    output logic                       o_clear,
    output logic                       o_strobe
);
    logic ctrlAct;
    logic startNow;
    logic clearNow;
    logic pulseNow;
    logic writeNow;

    // SKP reuses the pulse field as a condition, so TEST never fires a control
    assign ctrlAct  = i_sel && (i_cmd != ioCtrlPkg::TEST);
    assign startNow = ctrlAct && (i_pulse == ioCtrlPkg::START);
    assign clearNow = ctrlAct && (i_pulse == ioCtrlPkg::CLEAR);
    assign pulseNow = ctrlAct && (i_pulse == ioCtrlPkg::PULSE);
    assign writeNow = i_sel && (i_cmd == ioCtrlPkg::WRITE);

    // One-cycle control strobes to the device
    always_ff @(posedge SZMNC or posedge rst_DRL) begin
        if (rst_DRL) begin
            o_start  <= 1'b0;
            o_clear  <= 1'b0;
            o_strobe <= 1'b0;
        end else begin
            o_start  <= startNow;
            o_clear  <= clearNow;
            o_strobe <= pulseNow;
        end
    end

    // Busy/done handshake
    // start and clear win over a done pulse on the same edge
    always_ff @(posedge SZMNC or posedge rst_DRL) begin
        if (rst_DRL) begin
            o_busy <= 1'b0;
            o_done <= 1'b0;
        end else if (startNow) begin
            o_busy <= 1'b1;
            o_done <= 1'b0;
        end else if (clearNow) begin
            o_busy <= 1'b0;
            o_done <= 1'b0;
        end else if (i_devDone) begin
            o_busy <= 1'b0;
            o_done <= 1'b1;
        end
    end

    always_ff @(posedge SZMNC or posedge rst_DRL) begin
        if (rst_DRL) begin
            o_inBuf  <= '0;
            o_outBuf <= '0;
        end else begin
            if (i_devDone) begin
                o_inBuf <= i_devInData;
            end
            if (writeNow) begin
                o_outBuf <= i_acc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/intArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ioCtrl_defines.svh"

module intArbiter (
    input  wire                                        SZMNC,
    input  wire                                        rst_DRL,
    input  wire [`IO_NUM_CHAN-1:0]                     i_busy,
    input  wire [`IO_NUM_CHAN-1:0]                     i_done,
    input  wire [`IO_NUM_CHAN-1:0][`IO_WORD_W-1:0]     i_inBuf,
    input  wire [`IO_WORD_W-1:0]                       i_acc,
    input  wire [`IO_CHAN_IDX_W-1:0]                   i_chanIdx,
    input  wire                                        i_devRead,
    input  wire                                        i_skipTest,
    input  wire ioCtrlPkg::ioPulse_t                   i_skipCond,
    input  wire                                        i_cpuEnable,
    input  wire                                        i_cpuDisable,
    input  wire                                        i_cpuMask,
    input  wire                                        i_cpuAck,
    output logic                                       o_accWe,
    output logic [`IO_WORD_W-1:0]                      o_accData,
    output logic                                       o_skip,
    output logic                                       o_intReq,
    output logic [`IO_CODE_W-1:0]                      o_intCode
);
    logic                          sDevRead;
    logic                          sSkipTest;
    logic                          sCpuAck;
    logic [`IO_CHAN_IDX_W-1:0]     sChanIdx;
    ioCtrlPkg::ioPulse_t           sSkipCond;
    logic [`IO_NUM_CHAN-1:0]       intMask;
    logic                          intEn;
    logic [`IO_NUM_CHAN-1:0]       pending;
    logic [`IO_CODE_W-1:0]         selCode;
    logic                          skipHit;

    // Hold the instruction one edge so results see its own channel update
    always_ff @(posedge SZMNC or posedge rst_DRL) begin
        if (rst_DRL) begin
            sDevRead  <= 1'b0;
            sSkipTest <= 1'b0;
            sCpuAck   <= 1'b0;
        end else begin
            sDevRead  <= i_devRead;
            sSkipTest <= i_skipTest;
            sCpuAck   <= i_cpuAck;
        end
    end

    always_ff @(posedge SZMNC) begin
        sChanIdx  <= i_chanIdx;
        sSkipCond <= i_skipCond;
    end

    // Mask bit k blocks channel k
    always_ff @(posedge SZMNC or posedge rst_DRL) begin
        if (rst_DRL) begin
            intMask <= '0;
            intEn   <= 1'b0;
        end else begin
            if (i_cpuMask) begin
                intMask <= i_acc[`IO_NUM_CHAN-1:0];
            end
            if (i_cpuEnable) begin
                intEn <= 1'b1;
            end else if (i_cpuDisable) begin
                intEn <= 1'b0;
            end
        end
    end

    assign pending = i_done & ~intMask;

    // Lowest channel wins, scan runs downward
    always_comb begin
        selCode = '0;
        for (int k = `IO_NUM_CHAN - 1; k >= 0; k--) begin
            if (pending[k]) begin
                selCode = `IO_CODE_W'(`IO_FIRST_DEV + k);
            end
        end
    end

    always_comb begin
        case (sSkipCond)
            ioCtrlPkg::NONE:  skipHit = i_busy[sChanIdx];
            ioCtrlPkg::START: skipHit = !i_busy[sChanIdx];
            ioCtrlPkg::CLEAR: skipHit = i_done[sChanIdx];
            default:          skipHit = !i_done[sChanIdx];
        endcase
    end

    always_ff @(posedge SZMNC or posedge rst_DRL) begin
        if (rst_DRL) begin
            o_accWe   <= 1'b0;
            o_accData <= '0;
            o_skip    <= 1'b0;
            o_intReq  <= 1'b0;
            o_intCode <= '0;
        end else begin
            o_accWe   <= sDevRead || sCpuAck;
            // INTA hands back the same code as the request
            o_accData <= sDevRead ? i_inBuf[sChanIdx] :
                         sCpuAck  ? `IO_WORD_W'(selCode) : '0;
            o_skip    <= sSkipTest && skipHit;
            o_intReq  <= intEn && (|pending);
            o_intCode <= selCode;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ioCtrlTop.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ioCtrl_defines.svh"

module ioCtrlTop (
    input  wire                                        SZMNC,
    input  wire                                        rst_DRL,
    input  wire                                        i_instValid,
    input  wire [`IO_WORD_W-1:0]                       i_inst,
    input  wire [`IO_WORD_W-1:0]                       i_acc,
    input  wire [`IO_NUM_CHAN-1:0][`IO_WORD_W-1:0]     i_devInData,
    input  wire [`IO_NUM_CHAN-1:0]                     i_devDone,
    output wire [`IO_NUM_CHAN-1:0][`IO_WORD_W-1:0]     o_devOutData,
    output wire [`IO_NUM_CHAN-1:0]                     o_devStart,
    output wire [`IO_NUM_CHAN-1:0]                     o_devClear,
    output wire [`IO_NUM_CHAN-1:0]                     o_devStrobe,
    output wire                                        o_accWe,
    output wire [`IO_WORD_W-1:0]                       o_accData,
    output wire                                        o_skip,
    output wire                                        o_intReq,
    output wire [`IO_CODE_W-1:0]                       o_intCode
);
    wire [`IO_NUM_CHAN-1:0]                   chanSel;
    ioCtrlPkg::chanCmd_t                      chanCmd;
    ioCtrlPkg::ioPulse_t                      chanPulse;
    wire [`IO_WORD_W-1:0]                     accCopy;
    wire [`IO_CHAN_IDX_W-1:0]                 chanIdx;
    wire                                      devRead;
    wire                                      skipTest;
    wire                                      cpuEnable;
    wire                                      cpuDisable;
    wire                                      cpuMask;
    wire                                      cpuAck;
    wire [`IO_NUM_CHAN-1:0]                   chanBusy;
    wire [`IO_NUM_CHAN-1:0]                   chanDone;
    wire [`IO_NUM_CHAN-1:0][`IO_WORD_W-1:0]   chanInBuf;

    ioInstDecode i_ioInstDecode (
        .SZMNC(SZMNC), .rst_DRL(rst_DRL),
        .i_instValid(i_instValid), .i_inst(i_inst), .i_acc(i_acc),
        .o_chanSel(chanSel), .o_chanCmd(chanCmd), .o_pulse(chanPulse),
        .o_acc(accCopy), .o_chanIdx(chanIdx),
        .o_devRead(devRead), .o_skipTest(skipTest),
        .o_cpuEnable(cpuEnable), .o_cpuDisable(cpuDisable),
        .o_cpuMask(cpuMask), .o_cpuAck(cpuAck)
    );

    // Channel k serves device code 7+k
    for (genvar k = 0; k < `IO_NUM_CHAN; k++) begin : gChan
        devChannel i_devChannel (
            .SZMNC(SZMNC), .rst_DRL(rst_DRL),
            .i_sel(chanSel[k]), .i_cmd(chanCmd), .i_pulse(chanPulse), .i_acc(accCopy),
            .i_devInData(i_devInData[k]), .i_devDone(i_devDone[k]),
            .o_busy(chanBusy[k]), .o_done(chanDone[k]),
            .o_inBuf(chanInBuf[k]), .o_outBuf(o_devOutData[k]),
            .o_start(o_devStart[k]), .o_clear(o_devClear[k]), .o_strobe(o_devStrobe[k])
        );
    end

    intArbiter i_intArbiter (
        .SZMNC(SZMNC), .rst_DRL(rst_DRL),
        .i_busy(chanBusy), .i_done(chanDone), .i_inBuf(chanInBuf),
        .i_acc(accCopy), .i_chanIdx(chanIdx),
        .i_devRead(devRead), .i_skipTest(skipTest), .i_skipCond(chanPulse),
        .i_cpuEnable(cpuEnable), .i_cpuDisable(cpuDisable),
        .i_cpuMask(cpuMask), .i_cpuAck(cpuAck),
        .o_accWe(o_accWe), .o_accData(o_accData), .o_skip(o_skip),
        .o_intReq(o_intReq), .o_intCode(o_intCode)
    );

endmodule

`default_nettype wire

// ==== test/tbIoCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ioCtrl_defines.svh"

module tbIoCtrl;

    localparam int numCols  = 11;
    localparam int memDepth = 4096;
    localparam int maxSteps = memDepth / numCols;

    // Column order in the vector file
    localparam int colKind    = 0;
    localparam int colInst    = 1;
    localparam int colAcc     = 2;
    localparam int colChan    = 3;
    localparam int colData    = 4;
    localparam int colCtl     = 5;
    localparam int colWe      = 6;
    localparam int colAccData = 7;
    localparam int colSkip    = 8;
    localparam int colIntReq  = 9;
    localparam int colIntCode = 10;

    localparam logic [15:0] kindInst   = 16'h0001;
    localparam logic [15:0] kindDone   = 16'h0002;
    localparam logic [15:0] unusedWord = 16'hFFFF;

    logic                                    SZMNC;
    logic                                    rst_DRL;
    logic                                    instValid;
    logic [`IO_WORD_W-1:0]                   inst;
    logic [`IO_WORD_W-1:0]                   acc;
    logic [`IO_NUM_CHAN-1:0][`IO_WORD_W-1:0] devInData;
    logic [`IO_NUM_CHAN-1:0]                 devDone;

    wire [`IO_NUM_CHAN-1:0][`IO_WORD_W-1:0]  devOutData;
    wire [`IO_NUM_CHAN-1:0]                  devStart;
    wire [`IO_NUM_CHAN-1:0]                  devClear;
    wire [`IO_NUM_CHAN-1:0]                  devStrobe;
    wire                                     accWe;
    wire [`IO_WORD_W-1:0]                    accData;
    wire                                     skip;
    wire                                     intReq;
    wire [`IO_CODE_W-1:0]                    intCode;

    logic [15:0] vecMem [0:memDepth-1];
    int          numSteps;
    int          errorCount;
    int          checkCount;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    ioCtrlTop i_ioCtrlTop (
        .SZMNC(SZMNC), .rst_DRL(rst_DRL),
        .i_instValid(instValid), .i_inst(inst), .i_acc(acc),
        .i_devInData(devInData), .i_devDone(devDone),
        .o_devOutData(devOutData), .o_devStart(devStart),
        .o_devClear(devClear), .o_devStrobe(devStrobe),
        .o_accWe(accWe), .o_accData(accData), .o_skip(skip),
        .o_intReq(intReq), .o_intCode(intCode)
    );

    initial begin
        SZMNC = 1'b0;
        forever #4 SZMNC = ~SZMNC;
    end

    // Ends a run that stops making progress
    always @(posedge SZMNC) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: test did not finish within %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] vecField(input int step, input int col);
        return vecMem[12'(step * numCols + col)];
    endfunction

    task automatic compareValue(input string what, input int step,
                                input logic [15:0] got, input logic [15:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t step %0d: %s is %h, expected %h", $time, step, what, got, exp);
        end
    endtask

    task automatic driveStep(input int step);
        logic [15:0] kind;
        logic [3:0]  chan;
        instValid = 1'b0;
        inst      = '0;
        acc       = '0;
        devDone   = '0;
        devInData = '0;
        if (step < numSteps) begin
            kind = vecField(step, colKind);
            chan = 4'(vecField(step, colChan));
            if (kind == kindInst) begin
                instValid = 1'b1;
                inst      = vecField(step, colInst);
                acc       = vecField(step, colAcc);
            end else if (kind == kindDone) begin
                devDone[chan]   = 1'b1;
                devInData[chan] = vecField(step, colData);
            end
        end
    endtask

    // Strobes and output buffer, one edge after the channel update
    task automatic checkChannel(input int step);
        logic [3:0] chan;
        chan = 4'(vecField(step, colChan));
        if (vecField(step, colKind) == kindInst) begin
            compareValue("start/clear/strobe", step,
                         16'({devStart[chan], devClear[chan], devStrobe[chan]}),
                         vecField(step, colCtl));
            compareValue("output buffer", step, devOutData[chan], vecField(step, colData));
        end
    endtask

    task automatic checkResult(input int step);
        compareValue("accWe", step, 16'(accWe), vecField(step, colWe));
        compareValue("accData", step, accData, vecField(step, colAccData));
        compareValue("skip", step, 16'(skip), vecField(step, colSkip));
        compareValue("intReq", step, 16'(intReq), vecField(step, colIntReq));
        compareValue("intCode", step, 16'(intCode), vecField(step, colIntCode));
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        rst_DRL    = 1'b1;
        instValid  = 1'b0;
        inst       = '0;
        acc        = '0;
        devInData  = '0;
        devDone    = '0;
        errorCount = 0;
        checkCount = 0;

        for (int k = 0; k < memDepth; k++) begin
            vecMem[12'(k)] = unusedWord;
        end
        $readmemh("test/ioCtrl_vectors.txt", vecMem);
        numSteps = 0;
        while (numSteps < maxSteps && vecField(numSteps, colKind) != unusedWord) begin
            numSteps++;
        end
        if (numSteps == 0) begin
            $display("No vectors were read from test/ioCtrl_vectors.txt");
            errorCount++;
        end
        cycleLimit = 4 * numSteps + 20;

        repeat (2) @(posedge SZMNC);
        @(negedge SZMNC);
        rst_DRL = 1'b0;

        // Results of a step show up three falling edges after it is driven
        for (int t = 0; t < numSteps + 3; t++) begin
            @(negedge SZMNC);
            if (t >= 3) begin
                checkResult(t - 3);
            end
            if (t >= 2 && t - 2 < numSteps) begin
                checkChannel(t - 2);
            end
            driveStep(t);
        end

        $display("Steps: %0d, checks: %0d, errors: %0d", numSteps, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/ioCtrl_vectors.txt ====
// kind inst acc chan data ctl | we accData skip intReq intCode   (kind 0 idle, 1 inst, 2 done)
// data is device input for done, expected output buffer for inst; ctl is {start,clear,strobe}
0 0000 0000 0 0000 0 0 0000 0 0 00
1 6249 1234 2 1234 4 0 0000 0 0 00
1 6709 0000 2 1234 0 0 0000 1 0 00
0 0000 0000 0 0000 0 0 0000 0 0 00
1 604C 0000 5 0000 4 0 0000 0 0 00
0 0000 0000 0 0000 0 0 0000 0 0 00
1 670C 0000 5 0000 0 0 0000 1 0 00
0 0000 0000 0 0000 0 0 0000 0 0 0C
2 0000 0000 5 BEEF 0 0 0000 0 0 0C
1 678C 0000 5 0000 0 0 0000 1 0 0C
1 610C 0000 5 0000 0 1 BEEF 0 0 0C
1 674C 0000 5 0000 0 0 0000 1 0 0C
1 670C 0000 5 0000 0 0 0000 0 0 0C
1 67CC 0000 5 0000 0 0 0000 0 0 0C
1 608C 0000 5 0000 2 0 0000 0 0 00
1 678C 0000 5 0000 0 0 0000 0 0 00
1 67CC 0000 5 0000 0 0 0000 1 0 00
1 6749 0000 2 1234 0 0 0000 0 0 00
1 60C9 0000 2 1234 1 0 0000 0 0 00
1 607F 0000 0 0000 0 0 0000 0 1 0F
2 0000 0000 8 0808 0 0 0000 0 1 0A
2 0000 0000 3 0303 0 0 0000 0 1 0A
0 0000 0000 0 0000 0 0 0000 0 1 0A
1 613F 0000 0 0000 0 1 000A 0 1 0A
1 643F 0008 0 0000 0 0 0000 0 1 0F
1 613F 0000 0 0000 0 1 000F 0 1 0F
1 60BF 0000 0 0000 0 0 0000 0 0 0F
1 8249 FFFF 2 1234 0 0 0000 0 0 0F
1 6254 FFFF 2 1234 0 0 0000 0 0 0F
1 6349 FFFF 2 1234 0 0 0000 0 0 0F
1 6114 0000 2 1234 0 0 0000 0 0 0F
1 6709 0000 2 1234 0 0 0000 1 0 0F
0 0000 0000 0 0000 0 0 0000 0 0 0F
0 0000 0000 0 0000 0 0 0000 0 0 0F

// ==== list.f ====
+incdir+hdl
hdl/ioCtrlPkg.sv
hdl/ioInstDecode.sv
hdl/devChannel.sv
hdl/intArbiter.sv
hdl/ioCtrlTop.sv
test/tbIoCtrl.sv

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=simIoCtrl
LOG_FILE=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timescale 1ns/100ps --top-module tbIoCtrl \
    -f list.f -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG_FILE"; then
    echo "Testbench reported a failure, see $LOG_FILE"
    exit 1
fi

if ! grep -q "Result: PASSED" "$LOG_FILE"; then
    echo "No result line found in $LOG_FILE"
    exit 1
fi

exit 0
